// ==== source/hcost_pkg.sv ====
`default_nettype none

package hcost_pkg;

    // ----------------------------------------
    // Block geometry
    // ----------------------------------------
    localparam int PIX_W   = 8;
    localparam int BLK_PIX = 16;
    localparam int BLK_W   = BLK_PIX * PIX_W;

    // ----------------------------------------
    // Datapath widths
    // ----------------------------------------
    localparam int WGT_W  = 16;
    localparam int COST_W = 32;

    // Enough for groups of up to 16 candidates
    localparam int IDX_W = 4;

    // Minimum search state
    typedef enum logic {
        SEL_IDLE = 1'b0,
        SEL_SCAN = 1'b1
    } sel_state_t;

endpackage

`default_nettype wire

// ==== source/block_ingress.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_ingress
    import hcost_pkg::*;
#(
    parameter int FIFO_DEPTH  = 4,
    parameter int GROUP_SIZE  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             blk_valid_i,
    input  logic [BLK_W-1:0] blk_data_i,
    output logic             blk_credit_o,
    input  logic             res_credit_i,
    output logic             iss_valid_o,
    output logic [BLK_W-1:0] iss_data_o,
    output logic [IDX_W-1:0] iss_idx_o,
    output logic             iss_last_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    logic [BLK_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic [IDX_W-1:0] cand_cnt;
    logic [CRD_W-1:0] res_cred;
    logic             grp_open;
    logic             pop;
    logic             first_pop;
    logic             cand_last;

    // A nonzero candidate count means a group is under way
    assign grp_open  = (cand_cnt != '0);
    assign cand_last = (cand_cnt == IDX_W'(GROUP_SIZE - 1));

    // New groups only start against a free result credit
    assign pop       = (fill != '0) && (grp_open || (res_cred != '0));
    assign first_pop = pop && !grp_open;

    // ----------------------------------------
    // Control state
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            cand_cnt <= '0;
            res_cred <= CRD_W'(OUT_CREDITS);
        end else begin
            if (blk_valid_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr   <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                cand_cnt <= cand_last ? '0 : cand_cnt + 1'b1;
            end
            if (blk_valid_i && !pop) begin
                fill <= fill + 1'b1;
            end else if (!blk_valid_i && pop) begin
                fill <= fill - 1'b1;
            end
            // Reserve on group start, refill on each returned credit
            if (first_pop && !res_credit_i) begin
                res_cred <= res_cred - 1'b1;
            end else if (!first_pop && res_credit_i) begin
                res_cred <= res_cred + 1'b1;
            end
        end
    end

    // Issue side, one cycle behind the pop decision
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss_valid_o  <= 1'b0;
            blk_credit_o <= 1'b0;
            iss_idx_o    <= '0;
            iss_last_o   <= 1'b0;
        end else begin
            iss_valid_o  <= pop;
            blk_credit_o <= pop;
            if (pop) begin
                iss_idx_o  <= cand_cnt;
                iss_last_o <= cand_last;
            end
        end
    end

    // Block storage and issued payload
    always_ff @(posedge clk) begin
        if (blk_valid_i) begin
            mem[wr_ptr] <= blk_data_i;
        end
        if (pop) begin
            iss_data_o <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== source/weight_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_table
    import hcost_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cfg_we_i,
    input  logic [3:0]               cfg_addr_i,
    input  logic [WGT_W-1:0]         cfg_wdata_i,
    output logic [BLK_PIX*WGT_W-1:0] wgt_o
);

    logic [WGT_W-1:0] wgt_q [BLK_PIX];

    // One weight per coefficient, row-major
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < BLK_PIX; i++) begin
                wgt_q[i] <= WGT_W'(1);
            end
        end else if (cfg_we_i) begin
            wgt_q[cfg_addr_i] <= cfg_wdata_i;
        end
    end

    // Flatten for the cost pipeline
    always_comb begin
        for (int i = 0; i < BLK_PIX; i++) begin
            wgt_o[i*WGT_W +: WGT_W] = wgt_q[i];
        end
    end

endmodule

`default_nettype wire

// ==== source/hadamard_cost.sv ====
`timescale 1ns/1ps
`default_nettype none

module hadamard_cost
    import hcost_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     iss_valid_i,
    input  logic [BLK_W-1:0]         iss_data_i,
    input  logic [IDX_W-1:0]         iss_idx_i,
    input  logic                     iss_last_i,
    input  logic [BLK_PIX*WGT_W-1:0] wgt_i,
    output logic                     cost_valid_o,
    output logic signed [COST_W-1:0] cost_o,
    output logic [IDX_W-1:0]         cost_idx_o,
    output logic                     cost_last_o
);

    localparam int DIM   = 4;
    // Row sums of four pixels, then column sums of four rows
    localparam int ROW_W = PIX_W + 3;
    localparam int COL_W = PIX_W + 5;

    logic signed [ROW_W-1:0]  pix    [BLK_PIX];
    logic signed [ROW_W-1:0]  row_c  [BLK_PIX];
    logic signed [COL_W-1:0]  col_c  [BLK_PIX];
    logic signed [COL_W-1:0]  abs_q  [BLK_PIX];
    logic signed [WGT_W-1:0]  wgt    [BLK_PIX];
    logic signed [COST_W-1:0] pair_q [BLK_PIX/2];
    logic signed [COST_W-1:0] cost_sum;
    logic                     v1_q;
    logic                     v2_q;
    logic [IDX_W-1:0]         idx1_q;
    logic [IDX_W-1:0]         idx2_q;
    logic                     last1_q;
    logic                     last2_q;

    for (genvar k = 0; k < BLK_PIX; k++) begin : g_unpack
        assign pix[k] = {{(ROW_W - PIX_W){1'b0}}, iss_data_i[k*PIX_W +: PIX_W]};
        assign wgt[k] = wgt_i[k*WGT_W +: WGT_W];
    end

    // ----------------------------------------
    // Butterflies, rows first
    // ----------------------------------------
    for (genvar r = 0; r < DIM; r++) begin : g_row
        logic signed [ROW_W-1:0] a [DIM];
        assign a[0] = pix[DIM*r + 0] + pix[DIM*r + 2];
        assign a[1] = pix[DIM*r + 1] + pix[DIM*r + 3];
        assign a[2] = pix[DIM*r + 1] - pix[DIM*r + 3];
        assign a[3] = pix[DIM*r + 0] - pix[DIM*r + 2];
        assign row_c[DIM*r + 0] = a[0] + a[1];
        assign row_c[DIM*r + 1] = a[3] + a[2];
        assign row_c[DIM*r + 2] = a[3] - a[2];
        assign row_c[DIM*r + 3] = a[0] - a[1];
    end

    for (genvar c = 0; c < DIM; c++) begin : g_col
        logic signed [COL_W-1:0] b [DIM];
        assign b[0] = row_c[c]     + row_c[c + 8];
        assign b[1] = row_c[c + 4] + row_c[c + 12];
        assign b[2] = row_c[c + 4] - row_c[c + 12];
        assign b[3] = row_c[c]     - row_c[c + 8];
        assign col_c[c]      = b[0] + b[1];
        assign col_c[c + 4]  = b[3] + b[2];
        assign col_c[c + 8]  = b[3] - b[2];
        assign col_c[c + 12] = b[0] - b[1];
    end

    // Stage 1 magnitudes, stage 2 weighted pairs
    always_ff @(posedge clk) begin
        for (int k = 0; k < BLK_PIX; k++) begin
            abs_q[k] <= col_c[k][COL_W-1] ? -col_c[k] : col_c[k];
        end
        for (int j = 0; j < BLK_PIX/2; j++) begin
            pair_q[j] <= abs_q[2*j] * wgt[2*j] + abs_q[2*j + 1] * wgt[2*j + 1];
        end
    end

    // Final eight-way add sits after the second register
    always_comb begin
        cost_sum = '0;
        for (int j = 0; j < BLK_PIX/2; j++) begin
            cost_sum = cost_sum + pair_q[j];
        end
    end

    // Tags follow the data two cycles deep
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1_q    <= 1'b0;
            v2_q    <= 1'b0;
            idx1_q  <= '0;
            idx2_q  <= '0;
            last1_q <= 1'b0;
            last2_q <= 1'b0;
        end else begin
            v1_q    <= iss_valid_i;
            v2_q    <= v1_q;
            idx1_q  <= iss_idx_i;
            idx2_q  <= idx1_q;
            last1_q <= iss_last_i;
            last2_q <= last1_q;
        end
    end

    assign cost_valid_o = v2_q;
    assign cost_o       = cost_sum;
    assign cost_idx_o   = idx2_q;
    assign cost_last_o  = last2_q;

endmodule

`default_nettype wire

// ==== source/best_cost_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module best_cost_select
    import hcost_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cost_valid_i,
    input  logic signed [COST_W-1:0] cost_i,
    input  logic [IDX_W-1:0]         cost_idx_i,
    input  logic                     cost_last_i,
    output logic                     res_valid_o,
    output logic [IDX_W-1:0]         res_idx_o,
    output logic signed [COST_W-1:0] res_cost_o
);

    sel_state_t               state_q;
    logic                     take_new;
    logic [IDX_W-1:0]         best_idx_q;
    logic signed [COST_W-1:0] best_cost_q;
    logic [IDX_W-1:0]         nxt_idx;
    logic signed [COST_W-1:0] nxt_cost;

    // First candidate always wins; later ones need a strictly lower cost
    assign take_new = (state_q == SEL_IDLE) || (cost_i < best_cost_q);
    assign nxt_idx  = take_new ? cost_idx_i : best_idx_q;
    assign nxt_cost = take_new ? cost_i : best_cost_q;

    // ----------------------------------------
    // Group FSM and result strobe
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= SEL_IDLE;
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= cost_valid_i && cost_last_i;
            if (cost_valid_i) begin
                state_q <= cost_last_i ? SEL_IDLE : SEL_SCAN;
            end
        end
    end

    // Running minimum and result payload
    always_ff @(posedge clk) begin
        if (cost_valid_i) begin
            best_idx_q  <= nxt_idx;
            best_cost_q <= nxt_cost;
        end
        if (cost_valid_i && cost_last_i) begin
            res_idx_o  <= nxt_idx;
            res_cost_o <= nxt_cost;
        end
    end

endmodule

`default_nettype wire

// ==== source/hcost_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hcost_top
    import hcost_pkg::*;
#(
    parameter int FIFO_DEPTH  = 4,
    parameter int GROUP_SIZE  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     blk_valid_i,
    input  logic [BLK_W-1:0]         blk_data_i,
    output logic                     blk_credit_o,
    input  logic                     res_credit_i,
    output logic                     res_valid_o,
    output logic [IDX_W-1:0]         res_idx_o,
    output logic signed [COST_W-1:0] res_cost_o,
    input  logic                     cfg_we_i,
    input  logic [3:0]               cfg_addr_i,
    input  logic [WGT_W-1:0]         cfg_wdata_i
);

    logic                     iss_valid;
    logic [BLK_W-1:0]         iss_data;
    logic [IDX_W-1:0]         iss_idx;
    logic                     iss_last;
    logic                     cost_valid;
    logic signed [COST_W-1:0] cost;
    logic [IDX_W-1:0]         cost_idx;
    logic                     cost_last;
    logic [BLK_PIX*WGT_W-1:0] wgt;

    // ----------------------------------------
    // Input buffer and issue
    // ----------------------------------------
    block_ingress #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .GROUP_SIZE  (GROUP_SIZE),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_ingress (
        .clk          (clk),
        .rst_n        (rst_n),
        .blk_valid_i  (blk_valid_i),
        .blk_data_i   (blk_data_i),
        .blk_credit_o (blk_credit_o),
        .res_credit_i (res_credit_i),
        .iss_valid_o  (iss_valid),
        .iss_data_o   (iss_data),
        .iss_idx_o    (iss_idx),
        .iss_last_o   (iss_last)
    );

    weight_table u_weights (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .wgt_o       (wgt)
    );

    // ----------------------------------------
    // Cost pipeline and selection
    // ----------------------------------------
    hadamard_cost u_cost (
        .clk          (clk),
        .rst_n        (rst_n),
        .iss_valid_i  (iss_valid),
        .iss_data_i   (iss_data),
        .iss_idx_i    (iss_idx),
        .iss_last_i   (iss_last),
        .wgt_i        (wgt),
        .cost_valid_o (cost_valid),
        .cost_o       (cost),
        .cost_idx_o   (cost_idx),
        .cost_last_o  (cost_last)
    );

    best_cost_select u_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .cost_valid_i (cost_valid),
        .cost_i       (cost),
        .cost_idx_i   (cost_idx),
        .cost_last_i  (cost_last),
        .res_valid_o  (res_valid_o),
        .res_idx_o    (res_idx_o),
        .res_cost_o   (res_cost_o)
    );

endmodule

`default_nettype wire

// ==== tb/hcost_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module hcost_chk
    import hcost_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input wire logic             clk,
    input wire logic             rst_n,
    input wire logic             blk_valid_i,
    input wire logic             blk_credit_o,
    input wire logic             res_valid_o,
    input wire logic             cost_valid,
    input wire logic [IDX_W-1:0] cost_idx,
    input wire logic             cost_last
);

    int         outst;
    int         fail_cnt;
    sel_state_t sel_q;

    // Blocks held by the engine, and a mirror of the selector state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outst <= 0;
            sel_q <= SEL_IDLE;
        end else begin
            outst <= outst + int'(blk_valid_i) - int'(blk_credit_o);
            if (cost_valid) begin
                sel_q <= cost_last ? SEL_IDLE : SEL_SCAN;
            end
        end
    end

    // ----------------------------------------
    // Credit and protocol properties
    // ----------------------------------------
    a_send_credit: assert property (@(posedge clk) disable iff (!rst_n)
        blk_valid_i |-> outst < FIFO_DEPTH)
        else begin
            $error("block sent with no input credit left");
            fail_cnt++;
        end

    // Negative means a credit came back for a block never sent
    a_outst_range: assert property (@(posedge clk) disable iff (!rst_n)
        outst >= 0 && outst <= FIFO_DEPTH)
        else begin
            $error("outstanding block count outside zero to FIFO depth");
            fail_cnt++;
        end

    a_res_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid_o |=> !res_valid_o)
        else begin
            $error("result valid held longer than one cycle");
            fail_cnt++;
        end

    a_first_idx: assert property (@(posedge clk) disable iff (!rst_n)
        (cost_valid && sel_q == SEL_IDLE) |-> cost_idx == '0)
        else begin
            $error("group opened with a nonzero candidate index");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// ==== tb/hcost_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module hcost_tb;
    import hcost_pkg::*;

    localparam int FIFO_DEPTH  = 4;
    localparam int GROUP_SIZE  = 4;
    localparam int OUT_CREDITS = 2;
    localparam int CLK_NS      = 20;

    logic                     clk;
    logic                     rst_n;
    logic                     blk_valid_i;
    logic [BLK_W-1:0]         blk_data_i;
    logic                     blk_credit_o;
    logic                     res_credit_i;
    logic                     res_valid_o;
    logic [IDX_W-1:0]         res_idx_o;
    logic signed [COST_W-1:0] res_cost_o;
    logic                     cfg_we_i;
    logic [3:0]               cfg_addr_i;
    logic [WGT_W-1:0]         cfg_wdata_i;

    int          in_cred;
    int          credit_pulses;
    int          blocks_sent;
    int          groups_exp;
    int          results_seen;
    int          returned;
    int          errors;
    int          checks;
    int          wd_cycles;
    longint      hold_end;
    int unsigned gap_seed;
    int unsigned ret_seed;
    logic [IDX_W-1:0]  exp_idx_q[$];
    logic [COST_W-1:0] exp_cost_q[$];

    hcost_top #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .GROUP_SIZE  (GROUP_SIZE),
        .OUT_CREDITS (OUT_CREDITS)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .blk_valid_i  (blk_valid_i),
        .blk_data_i   (blk_data_i),
        .blk_credit_o (blk_credit_o),
        .res_credit_i (res_credit_i),
        .res_valid_o  (res_valid_o),
        .res_idx_o    (res_idx_o),
        .res_cost_o   (res_cost_o),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i)
    );

    bind hcost_top hcost_chk #(.FIFO_DEPTH(FIFO_DEPTH)) u_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .blk_valid_i  (blk_valid_i),
        .blk_credit_o (blk_credit_o),
        .res_valid_o  (res_valid_o),
        .cost_valid   (cost_valid),
        .cost_idx     (cost_idx),
        .cost_last    (cost_last)
    );

    function automatic int lcg_next(inout int unsigned s);
        s = s * 32'd1103515245 + 32'd12345;
        return int'(s[30:16]);
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // Own view of upstream credits
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_cred       <= FIFO_DEPTH;
            credit_pulses <= 0;
        end else begin
            in_cred <= in_cred - int'(blk_valid_i) + int'(blk_credit_o);
            if (blk_credit_o) begin
                credit_pulses <= credit_pulses + 1;
            end
        end
    end

    // ----------------------------------------
    // Result checks and credit returns
    // ----------------------------------------
    initial begin
        int pend;
        int g;
        pend = 0;
        res_credit_i = 1'b0;
        forever begin
            @(negedge clk);
            if (res_valid_o) begin
                g = results_seen;
                checks++;
                assert (results_seen < OUT_CREDITS + returned) else begin
                    $display("Error: result %0d issued with no result credit", g);
                    errors++;
                end
                if (exp_idx_q.size() == 0) begin
                    $display("Error: result %0d arrived with no group expected", g);
                    errors++;
                end else begin
                    assert (res_idx_o == exp_idx_q[0]) else begin
                        $display("Fail group%0d idx expected %0d actual %0d",
                                 g, exp_idx_q[0], res_idx_o);
                        errors++;
                    end
                    assert (res_cost_o == exp_cost_q[0]) else begin
                        $display("Fail group%0d cost expected %0d actual %0d",
                                 g, $signed(exp_cost_q[0]), res_cost_o);
                        errors++;
                    end
                    $display("group%0d done idx %0d cost %0d", g, res_idx_o, res_cost_o);
                    void'(exp_idx_q.pop_front());
                    void'(exp_cost_q.pop_front());
                end
                results_seen++;
                pend++;
            end
            if (pend > 0 && $time >= hold_end && lcg_next(ret_seed) % 3 == 0) begin
                res_credit_i = 1'b1;
                pend--;
                returned++;
            end else begin
                res_credit_i = 1'b0;
            end
        end
    end

    // Run limit scales with the number of blocks in the file
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Error: watchdog expired before all results arrived");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic send_block(input logic [BLK_W-1:0] d);
        int gap;
        gap = lcg_next(gap_seed) % 4;
        repeat (gap) @(negedge clk);
        while (in_cred == 0) @(negedge clk);
        blk_valid_i = 1'b1;
        blk_data_i  = d;
        @(negedge clk);
        blk_valid_i = 1'b0;
        blocks_sent++;
    endtask

    // Weights change only between groups
    task automatic write_weight(input int addr, input logic [WGT_W-1:0] w);
        wait (results_seen == groups_exp);
        @(negedge clk);
        cfg_we_i    = 1'b1;
        cfg_addr_i  = 4'(addr);
        cfg_wdata_i = w;
        @(negedge clk);
        cfg_we_i = 1'b0;
    endtask

    task automatic count_check(input string name, input int expv, input int actv);
        checks++;
        assert (expv == actv) else begin
            $display("Fail %s expected %0d actual %0d", name, expv, actv);
            errors++;
        end
        $display("%s done expected %0d actual %0d", name, expv, actv);
    endtask

    task automatic run_file();
        int fd;
        int n;
        int a;
        int nblk;
        string line;
        string cmd;
        logic [BLK_W-1:0] d;
        logic [COST_W-1:0] v;
        nblk = 0;
        fd = $fopen("tb/hcost_testdata.txt", "r");
        if (fd == 0) begin
            $display("Error: test data file could not be opened");
            errors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            n = $sscanf(line, "%s", cmd);
            if (n == 1 && cmd == "B") nblk++;
        end
        $fclose(fd);
        wd_cycles = 200 * nblk + 100;
        fd = $fopen("tb/hcost_testdata.txt", "r");
        while ($fgets(line, fd) > 0) begin
            n = $sscanf(line, "%s", cmd);
            if (n < 1 || cmd.substr(0, 0) == "#") continue;
            if (cmd == "B") begin
                n = $sscanf(line, "%s %h", cmd, d);
                send_block(d);
            end else if (cmd == "A") begin
                n = $sscanf(line, "%s %h", cmd, v);
                for (int i = 0; i < BLK_PIX; i++) write_weight(i, v[WGT_W-1:0]);
            end else if (cmd == "W") begin
                n = $sscanf(line, "%s %d %h", cmd, a, v);
                write_weight(a, v[WGT_W-1:0]);
            end else if (cmd == "H") begin
                n = $sscanf(line, "%s %d", cmd, a);
                hold_end = $time + longint'(a) * CLK_NS;
            end else if (cmd == "E") begin
                n = $sscanf(line, "%s %d %h", cmd, a, v);
                exp_idx_q.push_back(IDX_W'(a));
                exp_cost_q.push_back(v);
                groups_exp++;
            end
        end
        $fclose(fd);
        // Last result comes after the last credit pulse
        wait (results_seen == groups_exp);
        repeat (4) @(negedge clk);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        gap_seed = 32'd78861;
        ret_seed = 32'd78861;
        blk_valid_i = 1'b0;
        blk_data_i  = '0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = '0;
        cfg_wdata_i = '0;
        rst_n       = 1'b0;
        hold_end    = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            checks++;
            assert (!blk_credit_o && !res_valid_o) else begin
                $display("Error: credit or result strobe active before stimulus");
                errors++;
            end
        end
        $display("idle_after_reset done");
        run_file();
        count_check("input_credits", blocks_sent, credit_pulses);
        count_check("result_count", blocks_sent / GROUP_SIZE, results_seen);
        if (dut.u_chk.fail_cnt != 0) begin
            $display("Error: protocol checker flagged %0d assertion failures",
                     dut.u_chk.fail_cnt);
            errors++;
        end
        $display("checks %0d errors %0d groups %0d blocks %0d",
                 checks, errors, results_seen, blocks_sent);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hcost_top.f ====
source/hcost_pkg.sv
source/block_ingress.sv
source/weight_table.sv
source/hadamard_cost.sv
source/best_cost_select.sv
source/hcost_top.sv
tb/hcost_chk.sv
tb/hcost_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the hcost testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module hcost_tb \
    -f hcost_top.f -o hcost_sim > sim.log 2>&1 \
    && ./obj_dir/hcost_sim >> sim.log 2>&1 \
    || { cat sim.log; echo "simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || grep -q "TEST RESULT: PASS" sim.log

// ==== tb/hcost_testdata.txt ====
# W addr weight | A weight (all 16) | B 16 pixels hex, pixel 15 first | H hold cycles
# E idx cost closes a group of four blocks, cost as signed 32-bit hex
B 05050505050505050505050505050505
B 02020202020202020202020202020202
B 00000000000000000000000000000410
B 02020202020202020202020202020202
E 1 00000020
A 0000
W 0 0003
B 03030303030303030303030303030303
B 01010101010101010101010101010101
B 01010101010101010101010101010101
B 04040404040404040404040404040404
E 1 00000030
W 0 FFFE
B 01010101010101010101010101010101
B 08080808080808080808080808080808
B 08080808080808080808080808080808
B 02020202020202020202020202020202
E 1 FFFFFF00
H 60
B 00000000000000000000000000000000
B 01010101010101010101010101010101
B 00000000000000000000000000000000
B 03030303030303030303030303030303
E 3 FFFFFFA0
B 01010101010101010101010101010101
B 01010101010101010101010101010101
B 01010101010101010101010101010101
B 01010101010101010101010101010101
E 0 FFFFFFE0
